//--- build.f
+incdir+.
vga_pkg.sv
vga_timing.sv
vga_draw_background.sv
vga_draw_rect.sv
vga_mixer.sv
vga_apb_regs.sv
vga_top.sv
vga_tb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator and run; the exit status carries pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module vga_tb -o vga_sim &&
./obj_dir/vga_sim ||
exit 1

//--- vga_apb_regs.sv
/*
 * APB register slave
 * Rectangle position, size and colour with read-back, no wait states
 */
`timescale 1ns/1ps

`include "vga_settings.svh"

module vga_apb_regs (
        input  logic               clk,
        input  logic               rst,
        input  logic [11:0]        paddr,
        input  logic               psel,
        input  logic               penable,
        input  logic               pwrite,
        input  logic [31:0]        pwdata,
        output logic [31:0]        prdata,
        output logic               pready,
        output logic               pslverr,
        output vga_pkg::rect_cfg_t cfg
);

        vga_pkg::reg_word_u wr_word;
        vga_pkg::reg_word_u rd_word;
        logic               access;
        logic               addr_ok;

        assign wr_word = pwdata;
        assign access  = psel && penable;
        assign addr_ok = (paddr == `VGA_ADDR_POS) || (paddr == `VGA_ADDR_SIZE) ||
                         (paddr == `VGA_ADDR_COLOR);

        assign pready  = 1'b1;
        assign pslverr = access && !addr_ok;

        always_ff @(posedge clk) begin
                if (rst) begin
                        cfg <= '0;
                end else if (access && pwrite && addr_ok) begin
                        case (paddr)
                                `VGA_ADDR_POS: begin
                                        cfg.xpos <= wr_word.pos.x;
                                        cfg.ypos <= wr_word.pos.y;
                                end
                                // Size reuses the position layout
                                `VGA_ADDR_SIZE: begin
                                        cfg.width  <= wr_word.pos.x;
                                        cfg.height <= wr_word.pos.y;
                                end
                                default: begin
                                        cfg.color <= wr_word.color.rgb;
                                end
                        endcase
                end
        end

        // Read-back packs the fields the same way, unused bits stay 0
        always_comb begin
                rd_word = '0;
                case (paddr)
                        `VGA_ADDR_POS: begin
                                rd_word.pos.x = cfg.xpos;
                                rd_word.pos.y = cfg.ypos;
                        end
                        `VGA_ADDR_SIZE: begin
                                rd_word.pos.x = cfg.width;
                                rd_word.pos.y = cfg.height;
                        end
                        `VGA_ADDR_COLOR: begin
                                rd_word.color.rgb = cfg.color;
                        end
                        default: begin
                                rd_word = '0;
                        end
                endcase
        end

        assign prdata = rd_word;

        a_apb_setup: assert property (@(posedge clk) disable iff (rst)
                $rose(penable) |-> (psel && $past(psel)))
                else $error("penable rose without a setup phase");

endmodule

//--- vga_draw_background.sv
/*
 * Background stage
 * Paints the backdrop and a logo band of three vertical strokes and one
 * diagonal stroke, black during blanking
 */
`timescale 1ns/1ps

`include "vga_settings.svh"

module vga_draw_background (
        input  logic                 clk,
        input  logic                 rst,
        input  vga_pkg::vga_timing_t tim,
        output vga_pkg::vga_pixel_t  bg
);

        localparam int W     = `VGA_STROKE_W;
        localparam int X0    = `VGA_LOGO_X0;
        localparam int X1    = `VGA_LOGO_X0 + 3 * `VGA_STROKE_W;
        localparam int X2    = `VGA_LOGO_X0 + 6 * `VGA_STROKE_W;
        localparam int X_END = `VGA_LOGO_X0 + 7 * `VGA_STROKE_W;

        logic [11:0] dx;
        logic [11:0] dy;
        logic        in_band;
        logic        on_stroke;
        logic [11:0] rgb_nxt;

        // Offsets from the top left corner of the logo band
        assign dx = tim.hcount - 12'(X0);
        assign dy = tim.vcount - 12'(`VGA_LOGO_Y0);

        assign in_band = (tim.vcount >= `VGA_LOGO_Y0) && (tim.vcount <= `VGA_LOGO_Y1) &&
                         (tim.hcount >= X0) && (tim.hcount < X_END);

        always_comb begin
                on_stroke = 1'b0;
                if (in_band) begin
                        // Vertical strokes
                        if ((tim.hcount < X0 + W) ||
                            ((tim.hcount >= X1) && (tim.hcount < X1 + W)) ||
                            ((tim.hcount >= X2) && (tim.hcount < X2 + W))) begin
                                on_stroke = 1'b1;
                        end
                        // Diagonal falling to the right, W pixels thick
                        if ((dy >= dx) && (dy < dx + 12'(W))) begin
                                on_stroke = 1'b1;
                        end
                end
        end

        always_comb begin
                if (tim.hblnk || tim.vblnk) begin
                        rgb_nxt = 12'h000;
                end else if (on_stroke) begin
                        rgb_nxt = `VGA_LOGO_COLOR;
                end else begin
                        rgb_nxt = `VGA_BG_COLOR;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        bg <= '0;
                end else begin
                        bg.tim <= tim;
                        bg.rgb <= rgb_nxt;
                end
        end

endmodule

//--- vga_draw_rect.sv
/*
 * Rectangle stage
 * Flags pixels inside the configured rectangle, delays timing to match
 */
`timescale 1ns/1ps

module vga_draw_rect (
        input  logic                 clk,
        input  logic                 rst,
        input  vga_pkg::vga_timing_t tim,
        input  vga_pkg::rect_cfg_t   cfg,
        output logic                 hit,
        output vga_pkg::vga_timing_t rect_tim
);

        logic [12:0] x_end;
        logic [12:0] y_end;
        logic        in_x;
        logic        in_y;
        logic        hit_nxt;

        // One extra bit so a rectangle near the edge does not wrap
        assign x_end = {1'b0, cfg.xpos} + {1'b0, cfg.width};
        assign y_end = {1'b0, cfg.ypos} + {1'b0, cfg.height};

        assign in_x = (tim.hcount >= cfg.xpos) && ({1'b0, tim.hcount} < x_end);
        assign in_y = (tim.vcount >= cfg.ypos) && ({1'b0, tim.vcount} < y_end);

        assign hit_nxt = in_x && in_y && !tim.hblnk && !tim.vblnk;

        always_ff @(posedge clk) begin
                if (rst) begin
                        hit      <= 1'b0;
                        rect_tim <= '{hcount: '0, vcount: '0, hsync: 1'b1, hblnk: 1'b0,
                                      vsync: 1'b1, vblnk: 1'b0};
                end else begin
                        hit      <= hit_nxt;
                        rect_tim <= tim;
                end
        end

        // hit and rect_tim must stay aligned to the same pixel
        a_hit_unblanked: assert property (@(posedge clk) disable iff (rst)
                $rose(hit) |-> !(rect_tim.hblnk || rect_tim.vblnk))
                else $error("hit rose during blanking at h=%0d v=%0d",
                            rect_tim.hcount, rect_tim.vcount);

endmodule

//--- vga_mixer.sv
/*
 * Output mixer
 * Rectangle colour wins over the background, result is registered
 */
`timescale 1ns/1ps

module vga_mixer (
        input  logic                 clk,
        input  logic                 rst,
        input  vga_pkg::vga_pixel_t  bg,
        input  logic                 hit,
        input  vga_pkg::vga_timing_t rect_tim,
        input  vga_pkg::rect_cfg_t   cfg,
        output vga_pkg::vga_pixel_t  pix
);

        logic [11:0] rgb_nxt;

        assign rgb_nxt = hit ? cfg.color : bg.rgb;

        always_ff @(posedge clk) begin
                if (rst) begin
                        pix <= '{tim: '{hcount: '0, vcount: '0, hsync: 1'b1, hblnk: 1'b0,
                                        vsync: 1'b1, vblnk: 1'b0},
                                 rgb: '0};
                end else begin
                        pix.tim <= rect_tim;
                        pix.rgb <= rgb_nxt;
                end
        end

        // Both drawing stages must have the same latency
        a_stage_align: assert property (@(posedge clk) disable iff (rst)
                (bg.tim.hcount == rect_tim.hcount) && (bg.tim.vcount == rect_tim.vcount))
                else $error("stage mismatch bg h=%0d v=%0d rect h=%0d v=%0d",
                            bg.tim.hcount, bg.tim.vcount,
                            rect_tim.hcount, rect_tim.vcount);

endmodule

//--- vga_pkg.sv
/*
 * VGA pipeline types
 * Timing word, pixel word, rectangle configuration and APB register word
 */
package vga_pkg;

        typedef struct packed {
                logic [11:0] hcount;
                logic [11:0] vcount;
                logic        hsync;
                logic        hblnk;
                logic        vsync;
                logic        vblnk;
        } vga_timing_t;

        typedef struct packed {
                vga_timing_t tim;
                logic [11:0] rgb;
        } vga_pixel_t;

        typedef struct packed {
                logic [11:0] xpos;
                logic [11:0] ypos;
                logic [11:0] width;
                logic [11:0] height;
                logic [11:0] color;
        } rect_cfg_t;

        // Position view, also used for the size register
        typedef struct packed {
                logic [3:0]  rsvd_hi;
                logic [11:0] y;
                logic [3:0]  rsvd_lo;
                logic [11:0] x;
        } reg_pos_t;

        typedef struct packed {
                logic [19:0] rsvd;
                logic [11:0] rgb;
        } reg_color_t;

        typedef union packed {
                reg_pos_t   pos;
                reg_color_t color;
        } reg_word_u;

endpackage

//--- vga_settings.svh
/*
 * VGA pipeline settings
 * Display timing for 1024x768, logo geometry, colours and APB register map
 */
`ifndef VGA_SETTINGS_SVH
`define VGA_SETTINGS_SVH

// Horizontal timing in pixel clocks
`define VGA_H_ACTIVE     1024
`define VGA_H_FP         24
`define VGA_H_SYNC       136
`define VGA_H_BP         160
`define VGA_H_TOTAL      (`VGA_H_ACTIVE + `VGA_H_FP + `VGA_H_SYNC + `VGA_H_BP)
`define VGA_H_SYNC_START (`VGA_H_ACTIVE + `VGA_H_FP)
`define VGA_H_SYNC_END   (`VGA_H_SYNC_START + `VGA_H_SYNC)

// Vertical timing in lines
`define VGA_V_ACTIVE     768
`define VGA_V_FP         3
`define VGA_V_SYNC       6
`define VGA_V_BP         29
`define VGA_V_TOTAL      (`VGA_V_ACTIVE + `VGA_V_FP + `VGA_V_SYNC + `VGA_V_BP)
`define VGA_V_SYNC_START (`VGA_V_ACTIVE + `VGA_V_FP)
`define VGA_V_SYNC_END   (`VGA_V_SYNC_START + `VGA_V_SYNC)

// Colours, 4 bits per channel
`define VGA_BG_COLOR     12'h189
`define VGA_LOGO_COLOR   12'hff0

// Logo band, strokes start at X0, X0+3W and X0+6W
`define VGA_LOGO_X0      300
`define VGA_LOGO_Y0      620
`define VGA_LOGO_Y1      720
`define VGA_STROKE_W     20

// APB register map
`define VGA_ADDR_POS     12'h000
`define VGA_ADDR_SIZE    12'h004
`define VGA_ADDR_COLOR   12'h008

`endif

//--- vga_tb.sv
/*
 * Testbench for the VGA frame pipeline
 * Drives APB writes and reads over two frames and checks pix with assertions
 */
`timescale 1ns/1ps

`include "vga_settings.svh"

module vga_tb;

        localparam int H_TOTAL = `VGA_H_ACTIVE + `VGA_H_FP + `VGA_H_SYNC + `VGA_H_BP;
        localparam int V_TOTAL = `VGA_V_ACTIVE + `VGA_V_FP + `VGA_V_SYNC + `VGA_V_BP;
        localparam int HS_LO   = `VGA_H_ACTIVE + `VGA_H_FP;
        localparam int HS_HI   = HS_LO + `VGA_H_SYNC;
        localparam int VS_LO   = `VGA_V_ACTIVE + `VGA_V_FP;
        localparam int VS_HI   = VS_LO + `VGA_V_SYNC;
        localparam int W       = `VGA_STROKE_W;
        localparam longint FRAME_NS    = longint'(H_TOTAL) * V_TOTAL * 40;
        localparam longint WATCHDOG_NS = FRAME_NS * 5 / 2;

        logic                clk;
        logic                rst;
        logic [11:0]         paddr;
        logic                psel;
        logic                penable;
        logic                pwrite;
        logic [31:0]         pwdata;
        logic [31:0]         prdata;
        logic                pready;
        logic                pslverr;
        vga_pkg::vga_pixel_t pix;

        // Expected register contents
        logic [11:0] m_x, m_y, m_w, m_h, m_color;
        logic [31:0] lfsr;
        logic [31:0] exp_prdata;
        logic [11:0] exp_bg;
        logic        addr_valid;
        logic        in_rect;
        int          h, v, prev_h, prev_v, exp_h, exp_v;
        int          cycle, wr_cycle;
        logic        checks_on, settled, blank;

        vga_top dut_i (
                .clk     (clk),
                .rst     (rst),
                .paddr   (paddr),
                .psel    (psel),
                .penable (penable),
                .pwrite  (pwrite),
                .pwdata  (pwdata),
                .prdata  (prdata),
                .pready  (pready),
                .pslverr (pslverr),
                .pix     (pix)
        );

        always #20 clk = ~clk;

        task automatic abort_run(input string why);
                $display("%s", why);
                $display("tests failed");
                $fatal(1);
        endtask

        task automatic report_mismatch(input string name, input logic [31:0] got,
                                       input logic [31:0] exp);
                abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
        endtask

        // Taps 32, 22, 2, 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic take_bits(input int n, output logic [31:0] val);
                val = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = lfsr_next(lfsr);
                        val  = {val[30:0], lfsr[0]};
                end
        endtask

        // Strokes repeat every 3W within the band, the diagonal falls to the right
        function automatic logic on_logo(input int hc, input int vc);
                int x;
                int y;
                x = hc - `VGA_LOGO_X0;
                y = vc - `VGA_LOGO_Y0;
                if (vc < `VGA_LOGO_Y0 || vc > `VGA_LOGO_Y1 || x < 0 || x >= 7 * W) begin
                        return 1'b0;
                end
                if ((x % (3 * W)) < W) begin
                        return 1'b1;
                end
                return (y - x >= 0) && (y - x < W);
        endfunction

        always @(posedge clk) begin
                if (rst) begin
                        cycle <= 0;
                end else begin
                        cycle <= cycle + 1;
                end
        end

        always @(negedge clk) begin
                prev_h <= h;
                prev_v <= v;
        end

        assign h         = int'(pix.tim.hcount);
        assign v         = int'(pix.tim.vcount);
        assign blank     = pix.tim.hblnk || pix.tim.vblnk;
        assign checks_on = !rst && (cycle >= 4);
        assign settled   = (cycle - wr_cycle) >= 3;
        assign exp_h     = (prev_h == H_TOTAL - 1) ? 0 : prev_h + 1;

        always_comb begin
                exp_v = prev_v;
                if (prev_h == H_TOTAL - 1) begin
                        exp_v = (prev_v == V_TOTAL - 1) ? 0 : prev_v + 1;
                end
                in_rect = (h >= int'(m_x)) && (h < int'(m_x) + int'(m_w)) &&
                          (v >= int'(m_y)) && (v < int'(m_y) + int'(m_h));
                exp_bg = on_logo(h, v) ? `VGA_LOGO_COLOR : `VGA_BG_COLOR;
                addr_valid = (paddr == `VGA_ADDR_POS) || (paddr == `VGA_ADDR_SIZE) ||
                             (paddr == `VGA_ADDR_COLOR);
                exp_prdata = '0;
                if (paddr == `VGA_ADDR_POS) begin
                        exp_prdata = {4'b0, m_y, 4'b0, m_x};
                end else if (paddr == `VGA_ADDR_SIZE) begin
                        exp_prdata = {4'b0, m_h, 4'b0, m_w};
                end else if (paddr == `VGA_ADDR_COLOR) begin
                        exp_prdata = {20'b0, m_color};
                end
        end

        a_blank_black: assert property (@(negedge clk) checks_on && blank |-> pix.rgb == 12'h0)
                else report_mismatch("pix.rgb", 32'(pix.rgb), 32'h0);
        a_hsync: assert property (@(negedge clk) checks_on |->
                pix.tim.hsync == !(h >= HS_LO && h < HS_HI))
                else report_mismatch("pix.hsync", 32'(pix.tim.hsync),
                                     32'(!(h >= HS_LO && h < HS_HI)));
        a_vsync: assert property (@(negedge clk) checks_on |->
                pix.tim.vsync == !(v >= VS_LO && v < VS_HI))
                else report_mismatch("pix.vsync", 32'(pix.tim.vsync),
                                     32'(!(v >= VS_LO && v < VS_HI)));
        a_hblnk: assert property (@(negedge clk) checks_on |->
                pix.tim.hblnk == (h >= `VGA_H_ACTIVE))
                else report_mismatch("pix.hblnk", 32'(pix.tim.hblnk), 32'(h >= `VGA_H_ACTIVE));
        a_vblnk: assert property (@(negedge clk) checks_on |->
                pix.tim.vblnk == (v >= `VGA_V_ACTIVE))
                else report_mismatch("pix.vblnk", 32'(pix.tim.vblnk), 32'(v >= `VGA_V_ACTIVE));
        a_hstep: assert property (@(negedge clk) checks_on |-> h == exp_h)
                else report_mismatch("pix.hcount", 32'(h), 32'(exp_h));
        a_vstep: assert property (@(negedge clk) checks_on |-> v == exp_v)
                else report_mismatch("pix.vcount", 32'(v), 32'(exp_v));
        a_background: assert property (@(negedge clk)
                checks_on && settled && !blank && !in_rect |-> pix.rgb == exp_bg)
                else report_mismatch("pix.rgb", 32'(pix.rgb), 32'(exp_bg));
        a_rect_color: assert property (@(negedge clk)
                checks_on && settled && !blank && in_rect |-> pix.rgb == m_color)
                else report_mismatch("pix.rgb", 32'(pix.rgb), 32'(m_color));
        a_pready: assert property (@(negedge clk) checks_on |-> pready)
                else report_mismatch("pready", 32'(pready), 32'h1);
        a_pslverr: assert property (@(negedge clk) psel && penable |-> pslverr == !addr_valid)
                else report_mismatch("pslverr", 32'(pslverr), 32'(!addr_valid));
        a_prdata: assert property (@(negedge clk)
                psel && penable && !pwrite && addr_valid |-> prdata == exp_prdata)
                else report_mismatch("prdata", prdata, exp_prdata);

        task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
                paddr   = addr;
                pwdata  = data;
                pwrite  = 1'b1;
                psel    = 1'b1;
                penable = 1'b0;
                @(posedge clk);
                #2 penable = 1'b1;
                @(posedge clk);
                #1;
                // Registers take the write at this edge
                if (addr == `VGA_ADDR_POS) begin
                        m_x = data[11:0];
                        m_y = data[27:16];
                end else if (addr == `VGA_ADDR_SIZE) begin
                        m_w = data[11:0];
                        m_h = data[27:16];
                end else if (addr == `VGA_ADDR_COLOR) begin
                        m_color = data[11:0];
                end
                wr_cycle = cycle;
                #1;
                psel    = 1'b0;
                penable = 1'b0;
                pwrite  = 1'b0;
        endtask

        task automatic apb_read(input logic [11:0] addr);
                paddr   = addr;
                pwrite  = 1'b0;
                psel    = 1'b1;
                penable = 1'b0;
                @(posedge clk);
                #2 penable = 1'b1;
                @(posedge clk);
                #2;
                psel    = 1'b0;
                penable = 1'b0;
        endtask

        // Returns 2 ns after the edge that follows the last pixel of a frame
        task automatic wait_frame_end();
                do begin
                        @(negedge clk);
                end while (!(h == H_TOTAL - 1 && v == V_TOTAL - 1));
                @(posedge clk);
                #2;
        endtask

        initial begin
                #(WATCHDOG_NS);
                abort_run("timeout: the run did not finish within 2.5 frame times");
        end

        initial begin
                logic [31:0] rx, ry, rw, rh, rc, noise;
                clk      = 1'b0;
                rst      = 1'b1;
                paddr    = '0;
                psel     = 1'b0;
                penable  = 1'b0;
                pwrite   = 1'b0;
                pwdata   = '0;
                lfsr     = 32'h4c13;
                wr_cycle = 0;
                {m_x, m_y, m_w, m_h, m_color} = '0;
                repeat (2) @(posedge clk);
                #2 rst = 1'b0;

                // First frame runs with the reset configuration
                wait_frame_end();
                take_bits(9, rx);
                take_bits(9, ry);
                take_bits(8, rw);
                take_bits(8, rh);
                take_bits(12, rc);
                take_bits(20, noise);
                apb_write(`VGA_ADDR_POS, {noise[7:4], ry[11:0], noise[3:0], rx[11:0]});
                apb_write(`VGA_ADDR_SIZE, {noise[15:12], rh[11:0] + 12'd16, noise[11:8],
                                           rw[11:0] + 12'd16});
                apb_write(`VGA_ADDR_COLOR, {noise[19:0], rc[11:0]});
                wait_frame_end();

                apb_read(`VGA_ADDR_POS);
                apb_read(`VGA_ADDR_SIZE);
                apb_read(`VGA_ADDR_COLOR);
                // Unmapped address must not disturb the colour
                apb_write(12'h00C, {noise[19:0], ~rc[11:0]});
                apb_read(`VGA_ADDR_COLOR);
                repeat (4) @(posedge clk);
                $display("all tests passed");
                $finish;
        end

endmodule

//--- vga_timing.sv
/*
 * VGA timing generator
 * Horizontal and vertical counters with negative sync and blanking flags
 */
`timescale 1ns/1ps

`include "vga_settings.svh"

module vga_timing (
        input  logic                 clk,
        input  logic                 rst,
        output vga_pkg::vga_timing_t tim
);

        logic [11:0] h_nxt;
        logic [11:0] v_nxt;

        // Next counter values, flags below are derived from them
        always_comb begin
                h_nxt = tim.hcount + 12'd1;
                v_nxt = tim.vcount;
                if (tim.hcount == `VGA_H_TOTAL - 1) begin
                        h_nxt = '0;
                        if (tim.vcount == `VGA_V_TOTAL - 1) begin
                                v_nxt = '0;
                        end else begin
                                v_nxt = tim.vcount + 12'd1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        tim <= '{hcount: '0, vcount: '0, hsync: 1'b1, hblnk: 1'b0,
                                 vsync: 1'b1, vblnk: 1'b0};
                end else begin
                        tim.hcount <= h_nxt;
                        tim.vcount <= v_nxt;
                        tim.hblnk  <= (h_nxt >= `VGA_H_ACTIVE);
                        tim.vblnk  <= (v_nxt >= `VGA_V_ACTIVE);
                        // Sync pulses are active low
                        tim.hsync  <= !((h_nxt >= `VGA_H_SYNC_START) &&
                                        (h_nxt < `VGA_H_SYNC_END));
                        tim.vsync  <= !((v_nxt >= `VGA_V_SYNC_START) &&
                                        (v_nxt < `VGA_V_SYNC_END));
                end
        end

        a_hcount_range: assert property (@(posedge clk) disable iff (rst)
                tim.hcount <= `VGA_H_TOTAL - 1)
                else $error("hcount out of range: %0d", tim.hcount);

endmodule

//--- vga_top.sv
/*
 * VGA frame pipeline top
 * Timing, two drawing stages, mixer and APB register block
 */
`timescale 1ns/1ps

module vga_top (
        input  logic                clk,
        input  logic                rst,
        input  logic [11:0]         paddr,
        input  logic                psel,
        input  logic                penable,
        input  logic                pwrite,
        input  logic [31:0]         pwdata,
        output logic [31:0]         prdata,
        output logic                pready,
        output logic                pslverr,
        output vga_pkg::vga_pixel_t pix
);

        vga_pkg::vga_timing_t tim;
        vga_pkg::vga_timing_t rect_tim;
        vga_pkg::vga_pixel_t  bg;
        vga_pkg::rect_cfg_t   cfg;
        logic                 hit;

        vga_timing timing_i (
                .clk (clk),
                .rst (rst),
                .tim (tim)
        );

        vga_draw_background bg_i (
                .clk (clk),
                .rst (rst),
                .tim (tim),
                .bg  (bg)
        );

        vga_draw_rect rect_i (
                .clk      (clk),
                .rst      (rst),
                .tim      (tim),
                .cfg      (cfg),
                .hit      (hit),
                .rect_tim (rect_tim)
        );

        vga_mixer mixer_i (
                .clk      (clk),
                .rst      (rst),
                .bg       (bg),
                .hit      (hit),
                .rect_tim (rect_tim),
                .cfg      (cfg),
                .pix      (pix)
        );

        vga_apb_regs regs_i (
                .clk     (clk),
                .rst     (rst),
                .paddr   (paddr),
                .psel    (psel),
                .penable (penable),
                .pwrite  (pwrite),
                .pwdata  (pwdata),
                .prdata  (prdata),
                .pready  (pready),
                .pslverr (pslverr),
                .cfg     (cfg)
        );

endmodule
